// File: uart_pkg.sv
package uart_pkg;

	// character format
	localparam int DATA_BITS      = 8;	// data bits per frame, sent lsb first
	localparam int FRAME_OVERHEAD = 2;	// one start bit plus one stop bit
	localparam int SYNC_STAGES    = 3;	// flops between the async line and the rx fsm

	// line levels
	localparam logic IDLE_LEVEL  = 1'b1;	// idle and stop bit level
	localparam logic START_LEVEL = 1'b0;	// start bit level

	// one data character
	typedef logic [DATA_BITS-1:0] uart_data_t;

	// index of the data bit in flight
	typedef logic [$clog2(DATA_BITS)-1:0] uart_bit_idx_t;

	// transmitter fsm
	typedef enum logic [2:0] {
		TX_IDLE,	// line high, waiting for a request
		TX_START,	// driving the start bit
		TX_DATA,	// driving data bits
		TX_PARITY,	// driving the parity bit
		TX_STOP	// driving the stop bit
	} uart_tx_state_t;

	// receiver fsm
	typedef enum logic [2:0] {
		RX_IDLE,	// waiting for a falling edge
		RX_START,	// half bit check of the start bit
		RX_DATA,	// sampling data bits
		RX_PARITY,	// sampling the parity bit
		RX_STOP	// sampling the stop bit
	} uart_rx_state_t;

	// what the receiver reports per frame
	typedef struct packed {
		uart_data_t data;	// received character
		logic       parity_error;	// parity bit disagreed with the data
		logic       frame_error;	// stop bit sampled low
	} uart_rx_result_t;

endpackage

// File: uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
	parameter int PARITY_ENABLED = 1,	// 1 sends a parity bit after the data
	parameter int PARITY_ODD     = 0,	// 0 even parity, 1 odd parity
	parameter int CLOCKS_PER_BIT = 8	// clk cycles per bit, even and at least 4
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_enable,	// one cycle request
	input  uart_pkg::uart_data_t i_data,	// captured in the accepting cycle
	output logic                 o_serial_out,	// serial line, idles high
	output logic                 o_busy	// high for the whole frame
);

	// frame length in bits
	localparam int FRAME_BITS = uart_pkg::DATA_BITS + PARITY_ENABLED + uart_pkg::FRAME_OVERHEAD;
	localparam int CNT_W      = $clog2(CLOCKS_PER_BIT);	// bit time counter width

	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLOCKS_PER_BIT - 1);	// last cycle of a bit
	localparam uart_pkg::uart_bit_idx_t LAST_BIT =
		uart_pkg::uart_bit_idx_t'(uart_pkg::DATA_BITS - 1);	// last data bit index

	uart_pkg::uart_tx_state_t state;	// current bit type
	uart_pkg::uart_tx_state_t state_next;
	logic [CNT_W-1:0]         baud_cnt;	// cycles spent in the current bit
	uart_pkg::uart_bit_idx_t  bit_idx;	// data bit in flight
	logic [FRAME_BITS-1:0]    shift_reg;	// frame shifted out lsb first
	logic [FRAME_BITS-1:0]    frame_word;	// frame built from the request
	logic                     parity_bit;
	logic                     accept;	// request taken this cycle
	logic                     bit_done;	// last cycle of the current bit

	// even parity is the xor of the data, odd parity its inverse
	assign parity_bit = (^i_data) ^ (PARITY_ODD != 0);

	assign accept   = i_enable && (state == uart_pkg::TX_IDLE);	// enables while busy are dropped
	assign bit_done = (baud_cnt == LAST_CNT);

	// stop, [parity], data, start from msb down to lsb
	always_comb begin
		frame_word = '1;
		frame_word[0] = uart_pkg::START_LEVEL;	// start bit goes out first
		frame_word[uart_pkg::DATA_BITS:1] = i_data;	// data lsb right after start
		if (PARITY_ENABLED != 0) begin
			frame_word[uart_pkg::DATA_BITS+1] = parity_bit;	// parity just before stop
		end
		frame_word[FRAME_BITS-1] = uart_pkg::IDLE_LEVEL;	// stop bit
	end

	// one step per bit, parity state only when enabled
	always_comb begin
		state_next = state;
		case (state)
			uart_pkg::TX_IDLE: begin
				if (accept) begin
					state_next = uart_pkg::TX_START;
				end
			end
			uart_pkg::TX_START: begin
				if (bit_done) begin
					state_next = uart_pkg::TX_DATA;
				end
			end
			uart_pkg::TX_DATA: begin
				if (bit_done && (bit_idx == LAST_BIT)) begin
					state_next = (PARITY_ENABLED != 0) ? uart_pkg::TX_PARITY : uart_pkg::TX_STOP;
				end
			end
			uart_pkg::TX_PARITY: begin
				if (bit_done) begin
					state_next = uart_pkg::TX_STOP;
				end
			end
			uart_pkg::TX_STOP: begin
				if (bit_done) begin
					state_next = uart_pkg::TX_IDLE;	// back to back frames possible next cycle
				end
			end
			default: begin
				state_next = uart_pkg::TX_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= uart_pkg::TX_IDLE;
			baud_cnt  <= '0;
			bit_idx   <= '0;
			shift_reg <= '1;	// line high out of reset
		end else begin
			state <= state_next;
			if (accept) begin
				shift_reg <= frame_word;	// start bit on the line next cycle
				baud_cnt  <= '0;	// bit time restarts with every frame
				bit_idx   <= '0;
			end else if (state != uart_pkg::TX_IDLE) begin
				if (bit_done) begin
					baud_cnt  <= '0;
					shift_reg <= {uart_pkg::IDLE_LEVEL, shift_reg[FRAME_BITS-1:1]};	// refill with idle
					if (state == uart_pkg::TX_DATA) begin
						bit_idx <= bit_idx + 1'b1;	// wraps to zero after the last bit
					end
				end else begin
					baud_cnt <= baud_cnt + 1'b1;
				end
			end
		end
	end

	// line comes straight from a flop so it never glitches
	assign o_serial_out = shift_reg[0];

	// busy spans start through stop, FRAME_BITS * CLOCKS_PER_BIT cycles
	assign o_busy = (state != uart_pkg::TX_IDLE);

endmodule

// File: uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
	parameter int PARITY_ENABLED = 1,	// 1 expects a parity bit after the data
	parameter int PARITY_ODD     = 0,	// 0 even parity, 1 odd parity
	parameter int CLOCKS_PER_BIT = 8	// clk cycles per bit, even and at least 4
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      i_serial_in,	// asynchronous serial line
	output logic                      o_valid,	// one cycle pulse at the stop sample
	output uart_pkg::uart_rx_result_t o_result	// held until the next valid
);

	localparam int CNT_W = $clog2(CLOCKS_PER_BIT);	// bit time counter width

	localparam logic [CNT_W-1:0] LAST_CNT  = CNT_W'(CLOCKS_PER_BIT - 1);	// one bit after last sample
	localparam logic [CNT_W-1:0] MID_START = CNT_W'(CLOCKS_PER_BIT / 2 - 1);	// start bit middle
	localparam uart_pkg::uart_bit_idx_t LAST_BIT =
		uart_pkg::uart_bit_idx_t'(uart_pkg::DATA_BITS - 1);	// last data bit index

	logic [uart_pkg::SYNC_STAGES-1:0] sync_ff;	// metastability chain
	logic                             line;	// synchronized line
	logic                             line_prev;	// line one cycle earlier
	logic                             line_fall;	// idle to start transition

	uart_pkg::uart_rx_state_t state;	// current bit type
	uart_pkg::uart_rx_state_t state_next;
	logic [CNT_W-1:0]         baud_cnt;	// cycles since the last sample
	uart_pkg::uart_bit_idx_t  bit_idx;	// data bit being sampled
	uart_pkg::uart_data_t     data_sr;	// data shifted in lsb first
	logic                     parity_acc;	// running parity of data bits
	logic                     parity_err;	// parity check of this frame
	logic                     sample;	// sample point of the current bit

	// line enters at the lsb and leaves at the msb
	always_ff @(posedge clk) begin
		if (reset) begin
			sync_ff   <= '1;	// assume an idle line
			line_prev <= uart_pkg::IDLE_LEVEL;
		end else begin
			sync_ff   <= {sync_ff[uart_pkg::SYNC_STAGES-2:0], i_serial_in};
			line_prev <= line;
		end
	end

	assign line      = sync_ff[uart_pkg::SYNC_STAGES-1];
	assign line_fall = (line_prev == uart_pkg::IDLE_LEVEL) && (line == uart_pkg::START_LEVEL);

	// half a bit for the start check, a full bit between later samples
	assign sample = (state == uart_pkg::RX_START) ? (baud_cnt == MID_START) : (baud_cnt == LAST_CNT);

	always_comb begin
		state_next = state;
		case (state)
			uart_pkg::RX_IDLE: begin
				if (line_fall) begin
					state_next = uart_pkg::RX_START;
				end
			end
			uart_pkg::RX_START: begin
				if (sample) begin
					// still low at mid start means a real frame, else a glitch
					state_next = (line == uart_pkg::START_LEVEL) ? uart_pkg::RX_DATA : uart_pkg::RX_IDLE;
				end
			end
			uart_pkg::RX_DATA: begin
				if (sample && (bit_idx == LAST_BIT)) begin
					state_next = (PARITY_ENABLED != 0) ? uart_pkg::RX_PARITY : uart_pkg::RX_STOP;
				end
			end
			uart_pkg::RX_PARITY: begin
				if (sample) begin
					state_next = uart_pkg::RX_STOP;
				end
			end
			uart_pkg::RX_STOP: begin
				if (sample) begin
					state_next = uart_pkg::RX_IDLE;	// rearm in the middle of the stop bit
				end
			end
			default: begin
				state_next = uart_pkg::RX_IDLE;
			end
		endcase
	end

	// control and result registers
	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= uart_pkg::RX_IDLE;
			baud_cnt   <= '0;
			bit_idx    <= '0;
			parity_acc <= 1'b0;
			parity_err <= 1'b0;
			o_valid    <= 1'b0;
			o_result   <= '0;
		end else begin
			state   <= state_next;
			o_valid <= 1'b0;	// single cycle pulse
			if (state == uart_pkg::RX_IDLE) begin
				// the edge cycle already counts as the first low cycle
				baud_cnt   <= CNT_W'(1);
				bit_idx    <= '0;
				parity_acc <= (PARITY_ODD != 0);	// odd parity seeds a one
				parity_err <= 1'b0;	// stays clear with parity off
			end else if (sample) begin
				baud_cnt <= '0;
				case (state)
					uart_pkg::RX_DATA: begin
						parity_acc <= parity_acc ^ line;
						bit_idx    <= bit_idx + 1'b1;
					end
					uart_pkg::RX_PARITY: begin
						parity_err <= parity_acc ^ line;	// nonzero means a mismatch
					end
					uart_pkg::RX_STOP: begin
						o_valid                <= 1'b1;	// reported for good and bad stop bits
						o_result.data          <= data_sr;
						o_result.parity_error  <= parity_err;
						o_result.frame_error   <= (line != uart_pkg::IDLE_LEVEL);
					end
					default: begin
						parity_err <= parity_err;	// start check needs no update
					end
				endcase
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	// data shifter
	always_ff @(posedge clk) begin
		if ((state == uart_pkg::RX_DATA) && sample) begin
			data_sr <= {line, data_sr[uart_pkg::DATA_BITS-1:1]};	// lsb arrives first
		end
	end

endmodule

// File: uart_loopback.sv
`timescale 1ns/1ps

module uart_loopback #(
	parameter int PARITY_ENABLED = 1,	// 1 adds a parity bit to every frame
	parameter int PARITY_ODD     = 0,	// 0 even parity, 1 odd parity
	parameter int CLOCKS_PER_BIT = 8	// clk cycles per bit, even and at least 4
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      i_tx_enable,	// one cycle send request
	input  uart_pkg::uart_data_t      i_tx_data,	// character to send
	input  logic                      i_loopback,	// 1 rx hears tx, 0 rx hears i_serial_in
	input  logic                      i_serial_in,	// external line
	output logic                      o_serial_out,	// tx line
	output logic                      o_busy,	// tx frame in progress
	output logic                      o_rx_valid,	// one cycle result strobe
	output uart_pkg::uart_rx_result_t o_rx_result	// last received frame
);

	logic rx_line;	// line the receiver listens to

	uart_tx #(
		.PARITY_ENABLED(PARITY_ENABLED),
		.PARITY_ODD    (PARITY_ODD),
		.CLOCKS_PER_BIT(CLOCKS_PER_BIT)
	) uart_tx_i (
		.clk         (clk),
		.reset       (reset),
		.i_enable    (i_tx_enable),
		.i_data      (i_tx_data),
		.o_serial_out(o_serial_out),
		.o_busy      (o_busy)
	);

	// plain mux with no register so the receiver sees tx without extra delay
	assign rx_line = i_loopback ? o_serial_out : i_serial_in;

	uart_rx #(
		.PARITY_ENABLED(PARITY_ENABLED),
		.PARITY_ODD    (PARITY_ODD),
		.CLOCKS_PER_BIT(CLOCKS_PER_BIT)
	) uart_rx_i (
		.clk        (clk),
		.reset      (reset),
		.i_serial_in(rx_line),	// synchronized inside the receiver
		.o_valid    (o_rx_valid),
		.o_result   (o_rx_result)
	);

endmodule

// File: uart_loopback_properties.sv
`timescale 1ns/1ps

module uart_loopback_properties (
	input logic clk,
	input logic reset,
	input logic i_loopback,
	input logic o_serial_out,
	input logic o_busy,
	input logic o_rx_valid
);

	logic seen_valid;	// a result came back during this busy period

	always_ff @(posedge clk) begin
		if (reset) begin
			seen_valid <= 1'b0;
		end else if (!o_busy) begin
			seen_valid <= 1'b0;	// cleared between frames
		end else if (o_rx_valid) begin
			seen_valid <= 1'b1;
		end
	end

	busy_low_after_reset: assert property (@(posedge clk) reset |=> !o_busy)
		else $error("o_busy high in the cycle after reset");

	line_idle_high: assert property (@(posedge clk) disable iff (reset)
		!o_busy |-> o_serial_out)
		else $error("o_serial_out low while the transmitter is idle");

	valid_one_cycle: assert property (@(posedge clk) disable iff (reset)
		o_rx_valid |=> !o_rx_valid)
		else $error("o_rx_valid high for two cycles in a row");

	// the looped frame must come back before its stop bit ends
	loopback_result_first: assert property (@(posedge clk) disable iff (reset)
		(i_loopback && $fell(o_busy)) |-> seen_valid)
		else $error("o_busy fell in loopback with no o_rx_valid since it rose");

endmodule

bind uart_loopback uart_loopback_properties uart_loopback_properties_i (
	.clk         (clk),
	.reset       (reset),
	.i_loopback  (i_loopback),
	.o_serial_out(o_serial_out),
	.o_busy      (o_busy),
	.o_rx_valid  (o_rx_valid)
);

// File: tb_uart_loopback.sv
`timescale 1ns/1ps

module tb_uart_loopback;

	localparam int PARITY_ENABLED = 1;	// defaults of the top level
	localparam int PARITY_ODD     = 0;
	localparam int CPB            = 8;	// clocks per bit
	localparam int FRAME_BITS     = uart_pkg::DATA_BITS + PARITY_ENABLED + 2;
	localparam int FRAME_CYCLES   = FRAME_BITS * CPB;	// busy length of one frame
	localparam int LOOP_FRAMES    = 200;
	localparam int ERR_FRAMES     = 8;	// per error kind
	localparam int GLITCHES       = 8;
	localparam int MAX_GAP        = 15;	// idle cycles between loopback frames
	localparam int TIMEOUT_CYCLES = LOOP_FRAMES * (FRAME_CYCLES + MAX_GAP + 1)
		+ (2 * ERR_FRAMES + 2 * GLITCHES) * (FRAME_CYCLES + 3 * CPB) + 1000;

	logic                      clk = 1'b0;
	logic                      reset;
	logic                      i_tx_enable;
	uart_pkg::uart_data_t      i_tx_data;
	logic                      i_loopback;
	logic                      i_serial_in;
	logic                      o_serial_out;
	logic                      o_busy;
	logic                      o_rx_valid;
	uart_pkg::uart_rx_result_t o_rx_result;

	integer                    seed;
	int                        value_errors = 0;
	int                        other_errors = 0;
	int                        cycle_cnt = 0;
	string                     test_name = "reset";
	uart_pkg::uart_rx_result_t exp_q[$];	// frames sent but not yet received
	uart_pkg::uart_data_t      tx_frame_data = '0;	// data of the frame on o_serial_out
	int                        busy_cnt = 0;	// cycles of the current busy period
	int                        frame_pulses = 0;	// valid pulses seen during busy
	logic                      prev_busy = 1'b0;

	always #20 clk = ~clk;	// 40 ns period

	uart_loopback #(
		.PARITY_ENABLED(PARITY_ENABLED),
		.PARITY_ODD    (PARITY_ODD),
		.CLOCKS_PER_BIT(CPB)
	) uart_loopback_i (
		.clk         (clk),
		.reset       (reset),
		.i_tx_enable (i_tx_enable),
		.i_tx_data   (i_tx_data),
		.i_loopback  (i_loopback),
		.i_serial_in (i_serial_in),
		.o_serial_out(o_serial_out),
		.o_busy      (o_busy),
		.o_rx_valid  (o_rx_valid),
		.o_rx_result (o_rx_result)
	);

	// level of frame bit idx: start, data lsb first, parity, stop
	function automatic logic frame_bit(input uart_pkg::uart_data_t data, input int idx);
		if (idx == 0) begin
			return 1'b0;
		end else if (idx <= uart_pkg::DATA_BITS) begin
			return data[idx-1];
		end else if ((PARITY_ENABLED != 0) && (idx == uart_pkg::DATA_BITS + 1)) begin
			return (($countones(data) % 2) == 1) != (PARITY_ODD != 0);	// ones count ends even
		end
		return 1'b1;	// stop bit
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (expected === actual) else begin
			value_errors++;
			$display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// oldest outstanding frame against the reported result
	task automatic check_rx_result();
		uart_pkg::uart_rx_result_t exp;
		assert (exp_q.size() != 0) else begin
			other_errors++;
			$display("ERROR %s: o_rx_valid pulsed while no frame was outstanding", test_name);
		end
		if (exp_q.size() != 0) begin
			exp = exp_q.pop_front();
			compare_value({test_name, " data"}, 32'(exp.data), 32'(o_rx_result.data));
			compare_value({test_name, " parity_error"}, 32'(exp.parity_error),
				32'(o_rx_result.parity_error));
			compare_value({test_name, " frame_error"}, 32'(exp.frame_error),
				32'(o_rx_result.frame_error));
		end
	endtask

	// outputs only move on posedge so the falling edge sees them settled
	always @(negedge clk) begin
		if (o_busy === 1'b1) begin
			if (busy_cnt % CPB == CPB / 2) begin	// middle of a bit
				compare_value("tx_framing", 32'(frame_bit(tx_frame_data, busy_cnt / CPB)),
					32'(o_serial_out));
			end
			busy_cnt++;
		end else if (prev_busy) begin	// busy just fell
			compare_value("busy_length", 32'(FRAME_CYCLES), 32'(busy_cnt));
			compare_value("pulses_per_frame", 32'(1), 32'(frame_pulses));
			busy_cnt     = 0;
			frame_pulses = 0;
		end
		if (o_rx_valid === 1'b1) begin
			if (o_busy === 1'b1) begin
				frame_pulses++;	// loopback pulse lands inside the stop bit
			end
			check_rx_result();
		end
		prev_busy = (o_busy === 1'b1);
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: run stopped after %0d cycles before the tests finished", cycle_cnt);
			$display("errors: %0d value, %0d other", value_errors, other_errors);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic send_loopback(input uart_pkg::uart_data_t data, input int gap,
		input logic spam);
		uart_pkg::uart_rx_result_t exp;
		logic [31:0]               noise;
		while (o_busy === 1'b1) begin
			@(negedge clk);
		end
		repeat (gap) @(negedge clk);	// gap 0 means back to back
		exp.data         = data;
		exp.parity_error = 1'b0;
		exp.frame_error  = 1'b0;
		exp_q.push_back(exp);
		tx_frame_data = data;
		i_tx_enable   = 1'b1;
		i_tx_data     = data;
		@(negedge clk);
		i_tx_enable = 1'b0;
		compare_value("busy_rise", 32'(1), 32'(o_busy));	// one cycle after accept
		compare_value("start_bit_begin", 32'(0), 32'(o_serial_out));
		if (spam) begin
			while (o_busy === 1'b1) begin	// these requests must be dropped
				noise       = $random(seed);
				i_tx_enable = (noise[1:0] == 2'b00);
				i_tx_data   = noise[15:8];
				@(negedge clk);
			end
			i_tx_enable = 1'b0;
		end
	endtask

	// external frame on i_serial_in, optionally corrupted
	task automatic drive_frame(input uart_pkg::uart_data_t data, input logic bad_parity,
		input logic bad_stop);
		uart_pkg::uart_rx_result_t exp;
		logic                      bit_val;
		exp.data         = data;
		exp.parity_error = bad_parity && (PARITY_ENABLED != 0);
		exp.frame_error  = bad_stop;
		exp_q.push_back(exp);
		for (int idx = 0; idx < FRAME_BITS; idx++) begin
			bit_val = frame_bit(data, idx);
			if (bad_parity && (PARITY_ENABLED != 0) && (idx == uart_pkg::DATA_BITS + 1)) begin
				bit_val = ~bit_val;
			end
			if (bad_stop && (idx == FRAME_BITS - 1)) begin
				bit_val = 1'b0;
			end
			i_serial_in = bit_val;
			repeat (CPB) @(negedge clk);
		end
		i_serial_in = 1'b1;	// one idle bit so the next start edge is seen
		repeat (CPB) @(negedge clk);
	endtask

	task automatic drive_glitch(input int len);
		i_serial_in = 1'b0;
		repeat (len) @(negedge clk);
		i_serial_in = 1'b1;
		repeat (CPB) @(negedge clk);
	endtask

	task automatic wait_rx_drain();
		int waited;
		waited = 0;
		while ((exp_q.size() != 0) && (waited < 2 * FRAME_CYCLES)) begin
			@(posedge clk);
			waited++;
		end
		@(negedge clk);
		assert (exp_q.size() == 0) else begin
			other_errors++;
			$display("ERROR %s: %0d frames were sent but never received", test_name, exp_q.size());
		end
		exp_q.delete();
	endtask

	initial begin
		logic [31:0] rnd;
		int          glitch_len;
		seed        = 57;
		reset       = 1'b1;
		i_tx_enable = 1'b0;
		i_tx_data   = '0;
		i_loopback  = 1'b1;
		i_serial_in = 1'b1;
		repeat (8) @(negedge clk);
		reset = 1'b0;

		// quiet outputs with no traffic
		repeat (2 * CPB) begin
			@(negedge clk);
			compare_value("reset_line", 32'(1), 32'(o_serial_out));
			compare_value("reset_busy", 32'(0), 32'(o_busy));
			compare_value("reset_valid", 32'(0), 32'(o_rx_valid));
		end

		test_name = "loopback";
		for (int n = 0; n < LOOP_FRAMES; n++) begin
			rnd = $random(seed);
			send_loopback(rnd[7:0], (rnd[13:12] == 2'b00) ? 0 : int'(rnd[11:8]),
				rnd[15:14] == 2'b00);
		end
		wait_rx_drain();
		while (o_busy === 1'b1) begin
			@(negedge clk);
		end
		i_loopback = 1'b0;	// receiver now hears i_serial_in
		repeat (CPB) @(negedge clk);

		test_name = "parity_error";
		for (int n = 0; n < ERR_FRAMES; n++) begin
			rnd = $random(seed);
			drive_frame(rnd[7:0], 1'b1, 1'b0);
			wait_rx_drain();
		end

		test_name = "stop_error";
		for (int n = 0; n < ERR_FRAMES; n++) begin
			rnd = $random(seed);
			drive_frame(rnd[7:0], 1'b0, 1'b1);
			wait_rx_drain();
		end

		test_name = "glitch";
		for (int n = 0; n < GLITCHES; n++) begin
			rnd        = $random(seed);
			glitch_len = 1 + int'(rnd[15:8]) % (CPB / 2 - 2);	// below half a bit minus one
			drive_glitch(glitch_len);
			drive_frame(rnd[7:0], 1'b0, 1'b0);
			wait_rx_drain();
		end

		$display("errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: filelist.f
uart_pkg.sv
uart_tx.sv
uart_rx.sv
uart_loopback.sv
uart_loopback_properties.sv
tb_uart_loopback.sv

// File: run_sim.sh
#!/bin/sh
# build and run the uart loopback testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/1ps \
	--top-module tb_uart_loopback \
	-f filelist.f

./obj_dir/Vtb_uart_loopback > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
	echo "simulation reported failure, see sim.log"
	exit 1
fi

echo "simulation finished without failure"
exit 0
